//--- hdl/tomasulo_pkg.sv
package tomasulo_pkg;

  localparam int WORD_W = 32;   // datapath width, add and mul wrap here
  localparam int UNIT_W = 1;
  localparam int IDX_W  = 5;    // entry index, 31 stays reserved

  // which execution unit produced a tag
  typedef enum logic [UNIT_W-1:0] {
    unit_add = 1'b0,
    unit_mul = 1'b1
  } unit_e;

  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_mul = 2'd1,
    op_mv  = 2'd2,
    op_mvi = 2'd3
  } op_e;

  // producer tag, unit in the msb
  typedef struct packed {
    unit_e            unit;
    logic [IDX_W-1:0] idx;
  } tag_t;

  // register holds its own value, no producer pending
  localparam tag_t TAG_NONE = '1;

  function automatic tag_t make_tag(unit_e unit, logic [IDX_W-1:0] idx);
    tag_t t;
    t.unit = unit;
    t.idx  = idx;
    return t;
  endfunction

endpackage

//--- hdl/register_status.sv
`timescale 1ns/100ps

module register_status import tomasulo_pkg::*; #(
  parameter int NUM_REGS = 64
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [$clog2(NUM_REGS)-1:0] rs1,
  input  logic [$clog2(NUM_REGS)-1:0] rs2,
  input  logic [$clog2(NUM_REGS)-1:0] rd,
  input  logic                        rename_en,
  input  tag_t                        rename_tag,
  input  logic                        mvi_en,
  input  logic [WORD_W-1:0]           imm,
  input  logic                        cdb_valid,
  input  tag_t                        cdb_tag,
  input  logic [WORD_W-1:0]           cdb_value,
  input  logic [$clog2(NUM_REGS)-1:0] rd_sel,
  output tag_t                        src1_tag,
  output logic [WORD_W-1:0]           src1_value,
  output tag_t                        src2_tag,
  output logic [WORD_W-1:0]           src2_value,
  output logic [WORD_W-1:0]           reg_value,
  output tag_t                        reg_tag
);

  logic [WORD_W-1:0] values [NUM_REGS];
  tag_t              tags   [NUM_REGS];

  // writeback and rename
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        values[i] <= '0;
        tags[i]   <= TAG_NONE;
      end
    end else begin
      for (int i = 0; i < NUM_REGS; i++) begin
        // only registers still naming this producer take the result
        if (cdb_valid && tags[i] == cdb_tag) begin
          values[i] <= cdb_value;
          tags[i]   <= TAG_NONE;
        end
      end
      // issue comes later in program order, so it overrides the broadcast
      if (mvi_en) begin
        values[rd] <= imm;
        tags[rd]   <= TAG_NONE;
      end else if (rename_en) begin
        tags[rd] <= rename_tag;
      end
    end
  end

  // operand lookup with same-cycle bus bypass
  always_comb begin
    src1_tag   = tags[rs1];
    src1_value = values[rs1];
    if (cdb_valid && src1_tag == cdb_tag) begin
      src1_tag   = TAG_NONE;
      src1_value = cdb_value;
    end
  end

  always_comb begin
    src2_tag   = tags[rs2];
    src2_value = values[rs2];
    if (cdb_valid && src2_tag == cdb_tag) begin
      src2_tag   = TAG_NONE;
      src2_value = cdb_value;
    end
  end

  assign reg_value = values[rd_sel];   // debug read port
  assign reg_tag   = tags[rd_sel];

  // a broadcast of the reserved tag would clear every idle register
  a_cdb_tag_valid: assert property (
    @(posedge clk) disable iff (!arst_n) cdb_valid |-> cdb_tag != TAG_NONE
  );

endmodule

//--- hdl/issue_control.sv
`timescale 1ns/100ps

module issue_control import tomasulo_pkg::*; (
  input  logic             issue_valid,
  input  op_e              issue_op,
  input  logic             has_imm,
  input  logic             add_full,
  input  logic             mul_full,
  input  logic [IDX_W-1:0] add_free_idx,
  input  logic [IDX_W-1:0] mul_free_idx,
  output logic             issue_accept,
  output logic             add_alloc,
  output logic             mul_alloc,
  output logic             rename_en,
  output tag_t             rename_tag,
  output logic             mvi_en,
  output logic             alloc_use_imm,
  output logic             alloc_force_zero
);

  always_comb begin
    issue_accept = 1'b0;
    add_alloc    = 1'b0;
    mul_alloc    = 1'b0;
    mvi_en       = 1'b0;
    rename_tag   = TAG_NONE;
    unique case (issue_op)
      op_add, op_mv: begin   // register move rides the adder
        issue_accept = !add_full;
        add_alloc    = issue_valid && !add_full;
        rename_tag   = make_tag(unit_add, add_free_idx);
      end
      op_mul: begin
        issue_accept = !mul_full;
        mul_alloc    = issue_valid && !mul_full;
        rename_tag   = make_tag(unit_mul, mul_free_idx);
      end
      op_mvi: begin
        issue_accept = 1'b1;   // straight into the register file
        mvi_en       = issue_valid;
      end
      default: begin
        issue_accept = 1'b0;
      end
    endcase
  end

  assign rename_en = add_alloc || mul_alloc;

  // mv: rs1 + 0
  assign alloc_force_zero = issue_op == op_mv;
  assign alloc_use_imm    = has_imm && issue_op != op_mv;

endmodule

//--- hdl/reservation_station.sv
`timescale 1ns/100ps

module reservation_station import tomasulo_pkg::*; #(
  parameter int    RS_DEPTH = 4,
  parameter unit_e UNIT     = unit_add
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alloc,
  input  logic              alloc_use_imm,
  input  logic              alloc_force_zero,
  input  tag_t              src1_tag,
  input  logic [WORD_W-1:0] src1_value,
  input  tag_t              src2_tag,
  input  logic [WORD_W-1:0] src2_value,
  input  logic [WORD_W-1:0] imm,
  input  logic              cdb_valid,
  input  tag_t              cdb_tag,
  input  logic [WORD_W-1:0] cdb_value,
  input  logic              grant,
  output logic              full,
  output logic              empty,
  output logic [IDX_W-1:0]  free_idx,
  output logic              done,
  output tag_t              done_tag,
  output logic [WORD_W-1:0] done_value
);

  localparam int SEL_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] busy;
  logic [RS_DEPTH-1:0] rdy1;
  logic [RS_DEPTH-1:0] rdy2;
  tag_t                tag1 [RS_DEPTH];
  tag_t                tag2 [RS_DEPTH];
  logic [WORD_W-1:0]   val1 [RS_DEPTH];
  logic [WORD_W-1:0]   val2 [RS_DEPTH];

  logic [RS_DEPTH-1:0] ready;
  logic [SEL_W-1:0]    sel_slot;
  logic [SEL_W-1:0]    free_slot;
  logic [SEL_W-1:0]    done_slot;
  logic                sel_valid;
  logic                exec_en;
  logic [WORD_W-1:0]   op_a;
  logic [WORD_W-1:0]   op_b;
  logic [WORD_W-1:0]   exec_result;

  assign done_slot = done_tag.idx[SEL_W-1:0];

  // entry in the output register is not picked twice
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready[i] = busy[i] && rdy1[i] && rdy2[i] && !(done && done_tag.idx == IDX_W'(i));
    end
  end

  // lowest ready and lowest free entry
  always_comb begin
    sel_valid = 1'b0;
    sel_slot  = '0;
    free_slot = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (ready[i]) begin
        sel_valid = 1'b1;
        sel_slot  = SEL_W'(i);
      end
      if (!busy[i]) begin
        free_slot = SEL_W'(i);
      end
    end
  end

  assign full     = &busy;
  assign empty    = ~|busy;
  assign free_idx = IDX_W'(free_slot);
  assign exec_en  = sel_valid && (!done || grant);   // stall on ungranted result

  assign op_a = val1[sel_slot];
  assign op_b = val2[sel_slot];

  generate
    if (UNIT == unit_mul) begin : g_mul
      logic signed [2*WORD_W-1:0] product;
      assign product     = (2*WORD_W)'($signed(op_a)) * (2*WORD_W)'($signed(op_b));
      assign exec_result = product[WORD_W-1:0];   // low word only
    end else begin : g_add
      assign exec_result = op_a + op_b;
    end
  endgenerate

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
      rdy1 <= '0;
      rdy2 <= '0;
      done <= 1'b0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (cdb_valid && !rdy1[i] && tag1[i] == cdb_tag) begin
          rdy1[i] <= 1'b1;
        end
        if (cdb_valid && !rdy2[i] && tag2[i] == cdb_tag) begin
          rdy2[i] <= 1'b1;
        end
      end
      if (grant) begin
        busy[done_slot] <= 1'b0;   // result is on the bus
      end
      if (alloc) begin
        busy[free_slot] <= 1'b1;
        rdy1[free_slot] <= src1_tag == TAG_NONE;
        rdy2[free_slot] <= alloc_force_zero || alloc_use_imm || src2_tag == TAG_NONE;
      end
      if (exec_en) begin
        done <= 1'b1;
      end else if (grant) begin
        done <= 1'b0;
      end
    end
  end

  // operand and result payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (cdb_valid && !rdy1[i] && tag1[i] == cdb_tag) begin
        val1[i] <= cdb_value;
      end
      if (cdb_valid && !rdy2[i] && tag2[i] == cdb_tag) begin
        val2[i] <= cdb_value;
      end
    end
    if (alloc) begin
      tag1[free_slot] <= src1_tag;
      val1[free_slot] <= src1_value;
      tag2[free_slot] <= src2_tag;
      if (alloc_force_zero) begin
        val2[free_slot] <= '0;
      end else if (alloc_use_imm) begin
        val2[free_slot] <= imm;
      end else begin
        val2[free_slot] <= src2_value;
      end
    end
    if (exec_en) begin
      done_tag   <= make_tag(UNIT, IDX_W'(sel_slot));
      done_value <= exec_result;
    end
  end

  a_no_alloc_full: assert property (
    @(posedge clk) disable iff (!arst_n) alloc |-> !full
  );

  // granting an empty output register would free a live entry
  a_grant_done: assert property (
    @(posedge clk) disable iff (!arst_n) grant |-> done
  );

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter import tomasulo_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              add_done,
  input  tag_t              add_tag,
  input  logic [WORD_W-1:0] add_value,
  input  logic              mul_done,
  input  tag_t              mul_tag,
  input  logic [WORD_W-1:0] mul_value,
  output logic              add_grant,
  output logic              mul_grant,
  output logic              cdb_valid,
  output tag_t              cdb_tag,
  output logic [WORD_W-1:0] cdb_value
);

  unit_e last_unit;   // winner of the previous grant

  // on a tie the unit that did not win last time goes first
  assign add_grant = add_done && (!mul_done || last_unit == unit_mul);
  assign mul_grant = mul_done && (!add_done || last_unit == unit_add);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_unit <= unit_mul;
    end else if (add_grant) begin
      last_unit <= unit_add;
    end else if (mul_grant) begin
      last_unit <= unit_mul;
    end
  end

  assign cdb_valid = add_done || mul_done;
  assign cdb_tag   = add_grant ? add_tag : mul_tag;
  assign cdb_value = add_grant ? add_value : mul_value;

  // a station left waiting wins the following cycle
  a_add_no_starve: assert property (
    @(posedge clk) disable iff (!arst_n) add_done && !add_grant |=> add_grant
  );

  a_mul_no_starve: assert property (
    @(posedge clk) disable iff (!arst_n) mul_done && !mul_grant |=> mul_grant
  );

endmodule

//--- hdl/tomasulo_core.sv
`timescale 1ns/100ps

module tomasulo_core import tomasulo_pkg::*; #(
  parameter int NUM_REGS = 64,
  parameter int RS_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        issue_valid,
  input  op_e                         issue_op,
  input  logic [$clog2(NUM_REGS)-1:0] rd,
  input  logic [$clog2(NUM_REGS)-1:0] rs1,
  input  logic [$clog2(NUM_REGS)-1:0] rs2,
  input  logic                        has_imm,
  input  logic [WORD_W-1:0]           imm,
  output logic                        issue_accept,
  input  logic [$clog2(NUM_REGS)-1:0] rd_sel,
  output logic [WORD_W-1:0]           reg_value,
  output tag_t                        reg_tag,
  output logic                        idle
);

  tag_t              src1_tag;
  logic [WORD_W-1:0] src1_value;
  tag_t              src2_tag;
  logic [WORD_W-1:0] src2_value;
  logic              rename_en;
  tag_t              rename_tag;
  logic              mvi_en;
  logic              alloc_use_imm;
  logic              alloc_force_zero;
  logic              add_alloc;
  logic              mul_alloc;
  logic              add_full;
  logic              mul_full;
  logic              add_empty;
  logic              mul_empty;
  logic [IDX_W-1:0]  add_free_idx;
  logic [IDX_W-1:0]  mul_free_idx;
  logic              add_done;
  tag_t              add_tag;
  logic [WORD_W-1:0] add_value;
  logic              mul_done;
  tag_t              mul_tag;
  logic [WORD_W-1:0] mul_value;
  logic              add_grant;
  logic              mul_grant;
  logic              cdb_valid;
  tag_t              cdb_tag;
  logic [WORD_W-1:0] cdb_value;

  register_status #(.NUM_REGS(NUM_REGS)) regs (
    .clk, .arst_n, .rs1, .rs2, .rd, .rename_en, .rename_tag, .mvi_en, .imm,
    .cdb_valid, .cdb_tag, .cdb_value, .rd_sel,
    .src1_tag, .src1_value, .src2_tag, .src2_value, .reg_value, .reg_tag
  );

  issue_control issue (
    .issue_valid, .issue_op, .has_imm, .add_full, .mul_full, .add_free_idx, .mul_free_idx,
    .issue_accept, .add_alloc, .mul_alloc, .rename_en, .rename_tag, .mvi_en,
    .alloc_use_imm, .alloc_force_zero
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH), .UNIT(unit_add)) add_rs (
    .clk, .arst_n, .alloc(add_alloc), .alloc_use_imm, .alloc_force_zero,
    .src1_tag, .src1_value, .src2_tag, .src2_value, .imm,
    .cdb_valid, .cdb_tag, .cdb_value, .grant(add_grant),
    .full(add_full), .empty(add_empty), .free_idx(add_free_idx),
    .done(add_done), .done_tag(add_tag), .done_value(add_value)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH), .UNIT(unit_mul)) mul_rs (
    .clk, .arst_n, .alloc(mul_alloc), .alloc_use_imm, .alloc_force_zero,
    .src1_tag, .src1_value, .src2_tag, .src2_value, .imm,
    .cdb_valid, .cdb_tag, .cdb_value, .grant(mul_grant),
    .full(mul_full), .empty(mul_empty), .free_idx(mul_free_idx),
    .done(mul_done), .done_tag(mul_tag), .done_value(mul_value)
  );

  cdb_arbiter arb (
    .clk, .arst_n, .add_done, .add_tag, .add_value, .mul_done, .mul_tag, .mul_value,
    .add_grant, .mul_grant, .cdb_valid, .cdb_tag, .cdb_value
  );

  assign idle = add_empty && mul_empty;   // drain check

endmodule

//--- tests/tomasulo_tb_tasks.svh
`ifndef TOMASULO_TB_TASKS_SVH
`define TOMASULO_TB_TASKS_SVH

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic abort_run(input string reason);
    $display("ERROR in %s: %s", test_name, reason);
    $display("Simulation failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_word(input string what, input logic [WORD_W-1:0] expected,
                            input logic [WORD_W-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s", what);
    end
  endtask

  task automatic check_tag(input string what, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "%s", what);
    end
  endtask

  // held and retried each falling edge until accepted
  task automatic issue_step(input step_t s);
    int tries;
    tries = 0;
    @(negedge clk);
    issue_valid = 1'b1;
    issue_op    = s.op;
    rd          = s.rd;
    rs1         = s.rs1;
    rs2         = s.rs2;
    has_imm     = s.has_imm;
    imm         = s.imm;
    #1;
    if (s.op == op_mvi && !issue_accept) begin
      abort_run("an immediate move was refused");
    end
    while (!issue_accept) begin
      refusals++;
      tries++;
      if (tries > ISSUE_LIMIT) begin
        abort_run("an operation was refused for too many cycles");
      end
      @(negedge clk);
      #1;
    end
    model_issue(s);
    @(posedge clk);   // taken here
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    issue_valid = 1'b0;
    while (!idle) begin
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        abort_run("the stations did not drain in time");
      end
      @(negedge clk);
    end
  endtask

`endif

//--- tests/tomasulo_tb.sv
`timescale 1ns/100ps

module tomasulo_tb
  import tomasulo_pkg::*;
();

  localparam int NUM_REGS    = 16;
  localparam int RS_DEPTH    = 2;   // shallow, back-to-back issue fills it
  localparam int REG_W       = $clog2(NUM_REGS);
  localparam int RAND_OPS    = 40;
  localparam int ISSUE_LIMIT = 100;
  localparam int DRAIN_LIMIT = 1000;

  typedef struct packed {
    op_e               op;
    logic [REG_W-1:0]  rd;
    logic [REG_W-1:0]  rs1;
    logic [REG_W-1:0]  rs2;
    logic              has_imm;
    logic [WORD_W-1:0] imm;
  } step_t;

  typedef struct packed {
    logic [REG_W-1:0]  reg_idx;
    logic [WORD_W-1:0] value;
  } expect_t;

  logic              clk;
  logic              arst_n;
  logic              issue_valid;
  op_e               issue_op;
  logic [REG_W-1:0]  rd;
  logic [REG_W-1:0]  rs1;
  logic [REG_W-1:0]  rs2;
  logic              has_imm;
  logic [WORD_W-1:0] imm;
  logic              issue_accept;
  logic [REG_W-1:0]  rd_sel;
  logic [WORD_W-1:0] reg_value;
  tag_t              reg_tag;
  logic              idle;

  logic [WORD_W-1:0] model [NUM_REGS];
  logic [31:0]       lfsr_state;
  string             test_name;
  int                refusals;
  step_t             rand_table [RAND_OPS];

  // dependent chain, then r9 and r10 written twice
  step_t chain_table [13] = '{
    '{op_mvi, 4'd2,  4'd0,  4'd0, 1'b0, 32'hffff_fffd},
    '{op_mul, 4'd3,  4'd1,  4'd2, 1'b0, 32'h0},
    '{op_add, 4'd4,  4'd3,  4'd1, 1'b0, 32'h0},
    '{op_mv,  4'd5,  4'd4,  4'd9, 1'b1, 32'h1234},   // imm must be ignored
    '{op_mul, 4'd6,  4'd5,  4'd0, 1'b1, 32'h0001_0000},
    '{op_add, 4'd7,  4'd6,  4'd0, 1'b1, 32'h7fff_ffff},
    '{op_mul, 4'd8,  4'd7,  4'd7, 1'b0, 32'h0},
    '{op_mul, 4'd9,  4'd8,  4'd3, 1'b0, 32'h0},       // slow producer, loses
    '{op_add, 4'd9,  4'd1,  4'd0, 1'b1, 32'h5},
    '{op_mul, 4'd10, 4'd2,  4'd2, 1'b0, 32'h0},
    '{op_mvi, 4'd10, 4'd0,  4'd0, 1'b0, 32'h55},
    '{op_add, 4'd11, 4'd10, 4'd9, 1'b0, 32'h0},
    '{op_add, 4'd12, 4'd3,  4'd4, 1'b0, 32'h0}
  };

  // worked out by hand
  expect_t chain_expect [11] = '{
    '{4'd1,  32'h0000_0007},
    '{4'd2,  32'hffff_fffd},
    '{4'd3,  32'hffff_ffeb},   // 7 * -3
    '{4'd4,  32'hffff_fff2},
    '{4'd5,  32'hffff_fff2},
    '{4'd6,  32'hfff2_0000},
    '{4'd7,  32'h7ff1_ffff},   // wraps
    '{4'd9,  32'h0000_000c},
    '{4'd10, 32'h0000_0055},
    '{4'd11, 32'h0000_0061},
    '{4'd12, 32'hffff_ffdd}
  };

  tomasulo_core #(.NUM_REGS(NUM_REGS), .RS_DEPTH(RS_DEPTH)) dut0 (
    .clk, .arst_n, .issue_valid, .issue_op, .rd, .rs1, .rs2, .has_imm, .imm,
    .issue_accept, .rd_sel, .reg_value, .reg_tag, .idle
  );

  always #5 clk = ~clk;

  // in-order architectural result of one accepted step
  function automatic void model_issue(input step_t s);
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    longint            product;
    a = model[s.rs1];
    b = s.has_imm ? s.imm : model[s.rs2];
    product = longint'($signed(a)) * longint'($signed(b));
    case (s.op)
      op_add:  model[s.rd] = a + b;
      op_mul:  model[s.rd] = product[WORD_W-1:0];
      op_mv:   model[s.rd] = a;
      default: model[s.rd] = s.imm;
    endcase
  endfunction

  `include "tomasulo_tb_tasks.svh"

  task automatic compare_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      @(negedge clk);
      rd_sel = REG_W'(r);
      #1;
      check_word($sformatf("r%0d value", r), model[r], reg_value);
      check_tag($sformatf("r%0d tag", r), TAG_NONE, reg_tag);
    end
  endtask

  initial begin
    logic [31:0] bits;
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue_op    = op_add;
    rd          = '0;
    rs1         = '0;
    rs2         = '0;
    has_imm     = 1'b0;
    imm         = '0;
    rd_sel      = '0;
    refusals    = 0;
    lfsr_state  = 32'h0fa883e2;
    foreach (model[i]) model[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_name = "reset";
    if (!idle) begin
      abort_run("idle is low after reset");
    end
    compare_regs();

    test_name = "mvi";
    issue_step(step_t'{op_mvi, 4'd1, 4'd0, 4'd0, 1'b0, 32'd7});
    @(negedge clk);
    issue_valid = 1'b0;
    rd_sel      = 4'd1;
    #1;
    check_word("r1 value", 32'd7, reg_value);
    check_tag("r1 tag", TAG_NONE, reg_tag);

    test_name = "chain";
    foreach (chain_table[i]) issue_step(chain_table[i]);
    wait_idle();
    foreach (chain_expect[i]) begin
      @(negedge clk);
      rd_sel = chain_expect[i].reg_idx;
      #1;
      check_word($sformatf("r%0d", rd_sel), chain_expect[i].value, reg_value);
    end
    compare_regs();

    test_name = "random";
    foreach (rand_table[i]) begin
      bits = lfsr_take(2);
      rand_table[i].op = op_e'(bits[1:0]);
      bits = lfsr_take(REG_W);
      rand_table[i].rd = bits[REG_W-1:0];
      bits = lfsr_take(REG_W);
      rand_table[i].rs1 = bits[REG_W-1:0];
      bits = lfsr_take(REG_W);
      rand_table[i].rs2 = bits[REG_W-1:0];
      bits = lfsr_take(1);
      rand_table[i].has_imm = bits[0];
      rand_table[i].imm = lfsr_take(WORD_W);
    end
    refusals = 0;
    foreach (rand_table[i]) issue_step(rand_table[i]);
    wait_idle();
    compare_regs();
    if (refusals == 0) begin
      abort_run("the random table never saw a full station");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+tests
hdl/tomasulo_pkg.sv
hdl/register_status.sv
hdl/issue_control.sv
hdl/reservation_station.sv
hdl/cdb_arbiter.sv
hdl/tomasulo_core.sv
tests/tomasulo_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tomasulo_tb -f sources.f -o tomasulo_sim \
  && ./obj_dir/tomasulo_sim \
  || { echo "build or simulation failed"; exit 1; }
